// File: rv32_isa.svh
// rv32 isa patterns: casez match values for the supported rv32im instructions and wfi
`ifndef RV32_ISA_SVH
`define RV32_ISA_SVH

// fields: funct7 _ rs2 _ rs1 _ funct3 _ rd _ opcode
// u and j types
`define RV32_LUI    32'b????????????????????_?????_0110111
`define RV32_AUIPC  32'b????????????????????_?????_0010111
`define RV32_JAL    32'b????????????????????_?????_1101111
`define RV32_JALR   32'b???????_?????_?????_000_?????_1100111
// conditional branches
`define RV32_BEQ    32'b???????_?????_?????_000_?????_1100011
`define RV32_BNE    32'b???????_?????_?????_001_?????_1100011
`define RV32_BLT    32'b???????_?????_?????_100_?????_1100011
`define RV32_BGE    32'b???????_?????_?????_101_?????_1100011
`define RV32_BLTU   32'b???????_?????_?????_110_?????_1100011
`define RV32_BGEU   32'b???????_?????_?????_111_?????_1100011
// loads and stores
`define RV32_LB     32'b???????_?????_?????_000_?????_0000011
`define RV32_LH     32'b???????_?????_?????_001_?????_0000011
`define RV32_LW     32'b???????_?????_?????_010_?????_0000011
`define RV32_LBU    32'b???????_?????_?????_100_?????_0000011
`define RV32_LHU    32'b???????_?????_?????_101_?????_0000011
`define RV32_SB     32'b???????_?????_?????_000_?????_0100011
`define RV32_SH     32'b???????_?????_?????_001_?????_0100011
`define RV32_SW     32'b???????_?????_?????_010_?????_0100011
// register immediate ops
`define RV32_ADDI   32'b???????_?????_?????_000_?????_0010011
`define RV32_SLTI   32'b???????_?????_?????_010_?????_0010011
`define RV32_SLTIU  32'b???????_?????_?????_011_?????_0010011
`define RV32_XORI   32'b???????_?????_?????_100_?????_0010011
`define RV32_ORI    32'b???????_?????_?????_110_?????_0010011
`define RV32_ANDI   32'b???????_?????_?????_111_?????_0010011
`define RV32_SLLI   32'b0000000_?????_?????_001_?????_0010011
`define RV32_SRLI   32'b0000000_?????_?????_101_?????_0010011
`define RV32_SRAI   32'b0100000_?????_?????_101_?????_0010011
// register register ops
`define RV32_ADD    32'b0000000_?????_?????_000_?????_0110011
`define RV32_SUB    32'b0100000_?????_?????_000_?????_0110011
`define RV32_SLL    32'b0000000_?????_?????_001_?????_0110011
`define RV32_SLT    32'b0000000_?????_?????_010_?????_0110011
`define RV32_SLTU   32'b0000000_?????_?????_011_?????_0110011
`define RV32_XOR    32'b0000000_?????_?????_100_?????_0110011
`define RV32_SRL    32'b0000000_?????_?????_101_?????_0110011
`define RV32_SRA    32'b0100000_?????_?????_101_?????_0110011
`define RV32_OR     32'b0000000_?????_?????_110_?????_0110011
`define RV32_AND    32'b0000000_?????_?????_111_?????_0110011
// m extension, divides are not supported
`define RV32_MUL    32'b0000001_?????_?????_000_?????_0110011
`define RV32_MULH   32'b0000001_?????_?????_001_?????_0110011
`define RV32_MULHSU 32'b0000001_?????_?????_010_?????_0110011
`define RV32_MULHU  32'b0000001_?????_?????_011_?????_0110011
// system
`define RV32_CSRRW  32'b???????_?????_?????_001_?????_1110011
`define RV32_CSRRS  32'b???????_?????_?????_010_?????_1110011
`define RV32_CSRRC  32'b???????_?????_?????_011_?????_1110011
`define RV32_WFI    32'b0001000_00101_00000_000_00000_1110011

`endif

// File: sys_pkg.sv
// sys_pkg: shared widths, instruction views, control enums and pipeline packets for decode
package sys_pkg;

	//////////////////////////////////////////////////
	// widths and fixed values
	//////////////////////////////////////////////////

	// data path width for rv32
	localparam int xlen = 32;
	// x0 always reads zero
	localparam logic [4:0] zero_reg = 5'd0;
	// addi x0, x0, 0 is the canonical noop
	localparam logic [31:0] nop_inst = 32'h0000_0013;

	//////////////////////////////////////////////////
	// instruction formats
	//////////////////////////////////////////////////

	// one packed union, each view splits the same 32 bits by format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i;
		struct packed {
			// imm[11:5]
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			// imm[4:0]
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s;
		struct packed {
			// branch offsets are scrambled, bit 0 is implied zero
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b;
		struct packed {
			// upper 20 bits, low 12 are zero
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j;
	} inst_t;

	//////////////////////////////////////////////////
	// control encodings
	//////////////////////////////////////////////////

	// operand a source
	typedef enum logic [1:0] {
		opa_is_rs1  = 2'h0,
		opa_is_npc  = 2'h1,
		opa_is_pc   = 2'h2,
		opa_is_zero = 2'h3
	} alu_opa_select_t;

	// operand b source, also picks the immediate format
	typedef enum logic [2:0] {
		opb_is_rs2   = 3'h0,
		opb_is_i_imm = 3'h1,
		opb_is_s_imm = 3'h2,
		opb_is_b_imm = 3'h3,
		opb_is_u_imm = 3'h4,
		opb_is_j_imm = 3'h5
	} alu_opb_select_t;

	// rd field or no destination at all
	typedef enum logic {
		dest_rd   = 1'b0,
		dest_none = 1'b1
	} dest_reg_sel_t;

	// alu and multiplier functions, add is the noop value
	typedef enum logic [4:0] {
		alu_add    = 5'h00,
		alu_sub    = 5'h01,
		alu_slt    = 5'h02,
		alu_sltu   = 5'h03,
		alu_and    = 5'h04,
		alu_or     = 5'h05,
		alu_xor    = 5'h06,
		alu_sll    = 5'h07,
		alu_srl    = 5'h08,
		alu_sra    = 5'h09,
		alu_mul    = 5'h0a,
		alu_mulh   = 5'h0b,
		alu_mulhsu = 5'h0c,
		alu_mulhu  = 5'h0d
	} alu_func_t;

	// execution channel the rs dispatches into
	typedef enum logic [2:0] {
		ch_alu  = 3'h0,
		ch_mult = 3'h1,
		ch_ld   = 3'h2,
		ch_st   = 3'h3,
		ch_br   = 3'h4
	} channel_t;

	//////////////////////////////////////////////////
	// pipeline packets
	//////////////////////////////////////////////////

	// fetch to decode, 97 bits
	typedef struct packed {
		inst_t            inst;
		logic [xlen-1:0]  pc;
		logic [xlen-1:0]  npc;
		logic             valid;
	} if_id_packet_t;

	// rob retire write into the register file, 38 bits
	typedef struct packed {
		logic             valid;
		logic [4:0]       dest_reg_idx;
		logic [xlen-1:0]  dest_reg_value;
	} rob2reg_packet_t;

	// decoder output bundle
	typedef struct packed {
		alu_opa_select_t  opa_select;
		alu_opb_select_t  opb_select;
		dest_reg_sel_t    dest_reg;
		alu_func_t        alu_func;
		logic             rd_mem;
		logic             wr_mem;
		logic             cond_branch;
		logic             uncond_branch;
		logic             csr_op;
		logic             halt;
		logic             illegal;
		logic             valid;
		channel_t         channel;
	} decode_ctrl_t;

	// registered decode packet toward rename and dispatch
	typedef struct packed {
		inst_t            inst;
		logic [xlen-1:0]  pc;
		logic [xlen-1:0]  npc;
		logic [xlen-1:0]  rs1_value;
		logic [xlen-1:0]  rs2_value;
		logic [xlen-1:0]  imm;
		alu_opa_select_t  opa_select;
		alu_opb_select_t  opb_select;
		logic [4:0]       dest_reg_idx;
		alu_func_t        alu_func;
		logic             rd_mem;
		logic             wr_mem;
		logic             cond_branch;
		logic             uncond_branch;
		logic             csr_op;
		logic             halt;
		logic             illegal;
		logic             valid;
		channel_t         channel;
	} id_packet_t;

	// btb notify for branches and jumps
	typedef struct packed {
		logic [xlen-1:0]  pc;
		logic             valid;
	} id2btb_packet_t;

endpackage

// File: decoder.sv
// decoder: combinational map from fetched instruction bits to datapath control and channel
`include "rv32_isa.svh"

module decoder import sys_pkg::*; (
	input  if_id_packet_t if_packet,
	output decode_ctrl_t  ctrl
);

	always_comb begin
		// noop defaults, each pattern overrides only what it needs
		ctrl.opa_select    = opa_is_rs1;
		ctrl.opb_select    = opb_is_rs2;
		ctrl.dest_reg      = dest_none;
		ctrl.alu_func      = alu_add;
		ctrl.rd_mem        = 1'b0;
		ctrl.wr_mem        = 1'b0;
		ctrl.cond_branch   = 1'b0;
		ctrl.uncond_branch = 1'b0;
		ctrl.csr_op        = 1'b0;
		ctrl.halt          = 1'b0;
		ctrl.illegal       = 1'b0;
		ctrl.channel       = ch_alu;

		// an invalid slot decodes as a noop and never flags illegal
		if (if_packet.valid) begin
			casez (if_packet.inst)
				`RV32_LUI: begin
					ctrl.dest_reg   = dest_rd;
					ctrl.opa_select = opa_is_zero;
					ctrl.opb_select = opb_is_u_imm;
				end
				`RV32_AUIPC: begin
					ctrl.dest_reg   = dest_rd;
					ctrl.opa_select = opa_is_pc;
					ctrl.opb_select = opb_is_u_imm;
				end
				// jumps write the link register
				`RV32_JAL: begin
					ctrl.dest_reg      = dest_rd;
					ctrl.opa_select    = opa_is_pc;
					ctrl.opb_select    = opb_is_j_imm;
					ctrl.uncond_branch = 1'b1;
					ctrl.channel       = ch_br;
				end
				`RV32_JALR: begin
					ctrl.dest_reg      = dest_rd;
					ctrl.opb_select    = opb_is_i_imm;
					ctrl.uncond_branch = 1'b1;
					ctrl.channel       = ch_br;
				end
				`RV32_BEQ, `RV32_BNE, `RV32_BLT, `RV32_BGE, `RV32_BLTU, `RV32_BGEU: begin
					ctrl.opa_select  = opa_is_pc;
					ctrl.opb_select  = opb_is_b_imm;
					ctrl.cond_branch = 1'b1;
					ctrl.channel     = ch_br;
				end
				// address is rs1 plus the offset in both memory cases
				`RV32_LB, `RV32_LH, `RV32_LW, `RV32_LBU, `RV32_LHU: begin
					ctrl.dest_reg   = dest_rd;
					ctrl.opb_select = opb_is_i_imm;
					ctrl.rd_mem     = 1'b1;
					ctrl.channel    = ch_ld;
				end
				`RV32_SB, `RV32_SH, `RV32_SW: begin
					ctrl.opb_select = opb_is_s_imm;
					ctrl.wr_mem     = 1'b1;
					ctrl.channel    = ch_st;
				end
				// immediate alu ops share dest and operand b
				`RV32_ADDI, `RV32_SLTI, `RV32_SLTIU, `RV32_XORI, `RV32_ORI, `RV32_ANDI,
				`RV32_SLLI, `RV32_SRLI, `RV32_SRAI: begin
					ctrl.dest_reg   = dest_rd;
					ctrl.opb_select = opb_is_i_imm;
					casez (if_packet.inst)
						`RV32_SLTI:  ctrl.alu_func = alu_slt;
						`RV32_SLTIU: ctrl.alu_func = alu_sltu;
						`RV32_XORI:  ctrl.alu_func = alu_xor;
						`RV32_ORI:   ctrl.alu_func = alu_or;
						`RV32_ANDI:  ctrl.alu_func = alu_and;
						`RV32_SLLI:  ctrl.alu_func = alu_sll;
						`RV32_SRLI:  ctrl.alu_func = alu_srl;
						`RV32_SRAI:  ctrl.alu_func = alu_sra;
						default:     ctrl.alu_func = alu_add;
					endcase
				end
				`RV32_ADD:    ctrl.dest_reg = dest_rd;
				`RV32_SUB: begin
					ctrl.dest_reg = dest_rd;
					ctrl.alu_func = alu_sub;
				end
				`RV32_SLL, `RV32_SLT, `RV32_SLTU, `RV32_XOR,
				`RV32_SRL, `RV32_SRA, `RV32_OR, `RV32_AND: begin
					ctrl.dest_reg = dest_rd;
					casez (if_packet.inst)
						`RV32_SLL:  ctrl.alu_func = alu_sll;
						`RV32_SLT:  ctrl.alu_func = alu_slt;
						`RV32_SLTU: ctrl.alu_func = alu_sltu;
						`RV32_XOR:  ctrl.alu_func = alu_xor;
						`RV32_SRL:  ctrl.alu_func = alu_srl;
						`RV32_SRA:  ctrl.alu_func = alu_sra;
						`RV32_OR:   ctrl.alu_func = alu_or;
						default:    ctrl.alu_func = alu_and;
					endcase
				end
				// multiplies go to the mult channel
				`RV32_MUL, `RV32_MULH, `RV32_MULHSU, `RV32_MULHU: begin
					ctrl.dest_reg = dest_rd;
					ctrl.channel  = ch_mult;
					casez (if_packet.inst)
						`RV32_MULH:   ctrl.alu_func = alu_mulh;
						`RV32_MULHSU: ctrl.alu_func = alu_mulhsu;
						`RV32_MULHU:  ctrl.alu_func = alu_mulhu;
						default:      ctrl.alu_func = alu_mul;
					endcase
				end
				// csr ops only carry the flag, no csr state here
				`RV32_CSRRW, `RV32_CSRRS, `RV32_CSRRC: ctrl.csr_op = 1'b1;
				`RV32_WFI: ctrl.halt = 1'b1;
				default:   ctrl.illegal = 1'b1;
			endcase
		end

		// illegal encodings never leave decode as valid work
		ctrl.valid = if_packet.valid & ~ctrl.illegal;
	end

endmodule

// File: regfile.sv
// regfile: 32 x xlen register file, two combinational reads, one retire write, x0 tied to zero
module regfile import sys_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic [4:0]      rda_idx,
	input  logic [4:0]      rdb_idx,
	output logic [xlen-1:0] rda_out,
	output logic [xlen-1:0] rdb_out,
	input  rob2reg_packet_t wr
);

	// x0 has no storage
	logic [xlen-1:0] registers [1:31];

	// one read port: zero, then bypass, then storage
	function automatic logic [xlen-1:0] read_port(input logic [4:0] idx);
		if (idx == zero_reg) begin
			return '0;
		end
		// retire write in flight this cycle wins
		if (wr.valid && (wr.dest_reg_idx == idx)) begin
			return wr.dest_reg_value;
		end
		return registers[idx];
	endfunction

	always_comb begin
		rda_out = read_port(rda_idx);
		rdb_out = read_port(rdb_idx);
	end

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				registers[i] <= '0;
			end
		end else if (wr.valid && (wr.dest_reg_idx != zero_reg)) begin
			// writes aimed at x0 fall through here
			registers[wr.dest_reg_idx] <= wr.dest_reg_value;
		end
	end

endmodule

// File: id_latch.sv
// id_latch: forms immediate and dest index, builds decode and btb packets, registers them
module id_latch import sys_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            stall,
	input  if_id_packet_t   if_packet,
	input  decode_ctrl_t    ctrl,
	input  logic [xlen-1:0] rs1_value,
	input  logic [xlen-1:0] rs2_value,
	output id_packet_t      id_packet,
	output id2btb_packet_t  btb_packet
);

	inst_t           inst;
	logic [xlen-1:0] imm;
	id_packet_t      id_next;
	id2btb_packet_t  btb_next;

	assign inst = if_packet.inst;

	// sign-extended immediate in the format operand b asks for
	always_comb begin
		case (ctrl.opb_select)
			opb_is_i_imm: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			opb_is_s_imm: imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			opb_is_b_imm: imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
				inst.b.imm10_5, inst.b.imm4_1, 1'b0};
			opb_is_u_imm: imm = {inst.u.imm, 12'b0};
			opb_is_j_imm: imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
				inst.j.imm11, inst.j.imm10_1, 1'b0};
			// rs2 operand carries no immediate
			default:      imm = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// next packets
	//////////////////////////////////////////////////

	always_comb begin
		id_next.inst          = if_packet.inst;
		id_next.pc            = if_packet.pc;
		id_next.npc           = if_packet.npc;
		id_next.rs1_value     = rs1_value;
		id_next.rs2_value     = rs2_value;
		id_next.imm           = imm;
		id_next.opa_select    = ctrl.opa_select;
		id_next.opb_select    = ctrl.opb_select;
		// stores and branches land on x0
		id_next.dest_reg_idx  = (ctrl.dest_reg == dest_rd) ? inst.r.rd : zero_reg;
		id_next.alu_func      = ctrl.alu_func;
		id_next.rd_mem        = ctrl.rd_mem;
		id_next.wr_mem        = ctrl.wr_mem;
		id_next.cond_branch   = ctrl.cond_branch;
		id_next.uncond_branch = ctrl.uncond_branch;
		id_next.csr_op        = ctrl.csr_op;
		id_next.halt          = ctrl.halt;
		id_next.illegal       = ctrl.illegal;
		id_next.valid         = ctrl.valid;
		id_next.channel       = ctrl.channel;
		// btb only hears about control flow
		btb_next.pc           = if_packet.pc;
		btb_next.valid        = ctrl.valid & (ctrl.cond_branch | ctrl.uncond_branch);
	end

	// pipeline register, holds while stalled
	always_ff @(posedge clock) begin
		if (reset) begin
			// all-zero fields already decode as a noop apart from the instruction
			id_packet      <= '0;
			id_packet.inst <= nop_inst;
			btb_packet     <= '0;
		end else if (!stall) begin
			id_packet  <= id_next;
			btb_packet <= btb_next;
		end
	end

endmodule

// File: id_stage.sv
// id_stage: instruction decode top, decoder and register file in parallel feeding the latch
module id_stage import sys_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            stall,
	input  if_id_packet_t   if_id_packet_in,
	input  rob2reg_packet_t rob_retire_packet_in,
	output id_packet_t      id_packet_out,
	output id2btb_packet_t  id2btb_packet_out
);

	decode_ctrl_t    dec_ctrl;
	logic [xlen-1:0] rs1_value;
	logic [xlen-1:0] rs2_value;

	// control from the raw instruction
	decoder u_decoder (
		.if_packet (if_id_packet_in),
		.ctrl      (dec_ctrl)
	);

	// operand reads use the r view, retire writes come from the rob
	regfile u_regfile (
		.clock   (clock),
		.reset   (reset),
		.rda_idx (if_id_packet_in.inst.r.rs1),
		.rdb_idx (if_id_packet_in.inst.r.rs2),
		.rda_out (rs1_value),
		.rdb_out (rs2_value),
		.wr      (rob_retire_packet_in)
	);

	// merge and register
	id_latch u_id_latch (
		.clock      (clock),
		.reset      (reset),
		.stall      (stall),
		.if_packet  (if_id_packet_in),
		.ctrl       (dec_ctrl),
		.rs1_value  (rs1_value),
		.rs2_value  (rs2_value),
		.id_packet  (id_packet_out),
		.btb_packet (id2btb_packet_out)
	);

endmodule

// File: id_stage_asserts.sv
// id_stage_asserts: reference model of the decode stage with concurrent checks, bound to id_stage
`include "rv32_isa.svh"

module id_stage_asserts import sys_pkg::*; (
	input logic            clock,
	input logic            reset,
	input logic            stall,
	input if_id_packet_t   if_id_packet_in,
	input rob2reg_packet_t rob_retire_packet_in,
	input id_packet_t      id_packet_out,
	input id2btb_packet_t  id2btb_packet_out
);
	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far, watched by the testbench top
	int unsigned     error_count = 0;
	// shadow copy of the architectural registers
	logic [xlen-1:0] shadow [32];
	id_packet_t      next_exp;
	id_packet_t      exp_pkt;
	id2btb_packet_t  exp_btb;

	// register read as seen in the same cycle with x0 forced to zero
	function automatic logic [xlen-1:0] read_model(input logic [4:0] idx);
		logic [xlen-1:0] val;
		val = shadow[idx];
		if (rob_retire_packet_in.valid && rob_retire_packet_in.dest_reg_idx == idx) begin
			val = rob_retire_packet_in.dest_reg_value;
		end
		if (idx == 5'd0) begin
			val = '0;
		end
		return val;
	endfunction

	//////////////////////////////////////////////////
	// expected decode from the isa rules
	//////////////////////////////////////////////////

	// covers only the instructions the stimulus sends and treats the rest as illegal
	function automatic id_packet_t predict(input if_id_packet_t f);
		id_packet_t  p;
		logic [31:0] ins;
		logic        writes_rd;
		ins         = f.inst;
		p           = '0;
		writes_rd   = 1'b0;
		p.inst      = f.inst;
		p.pc        = f.pc;
		p.npc       = f.npc;
		p.rs1_value = read_model(ins[19:15]);
		p.rs2_value = read_model(ins[24:20]);
		if (f.valid) begin
			casez (ins)
				`RV32_ADD: writes_rd = 1'b1;
				`RV32_SUB: begin
					writes_rd  = 1'b1;
					p.alu_func = alu_sub;
				end
				`RV32_AND: begin
					writes_rd  = 1'b1;
					p.alu_func = alu_and;
				end
				`RV32_XOR: begin
					writes_rd  = 1'b1;
					p.alu_func = alu_xor;
				end
				`RV32_MUL: begin
					writes_rd = 1'b1;
					p.channel = ch_mult;
					p.alu_func = alu_mul;
				end
				`RV32_MULHU: begin
					writes_rd  = 1'b1;
					p.channel  = ch_mult;
					p.alu_func = alu_mulhu;
				end
				`RV32_ADDI: begin
					writes_rd    = 1'b1;
					p.opb_select = opb_is_i_imm;
					p.imm        = {{20{ins[31]}}, ins[31:20]};
				end
				`RV32_LW: begin
					writes_rd    = 1'b1;
					p.rd_mem     = 1'b1;
					p.channel    = ch_ld;
					p.opb_select = opb_is_i_imm;
					p.imm        = {{20{ins[31]}}, ins[31:20]};
				end
				// stores have no destination
				`RV32_SW: begin
					p.wr_mem     = 1'b1;
					p.channel    = ch_st;
					p.opb_select = opb_is_s_imm;
					p.imm        = {{20{ins[31]}}, ins[31:25], ins[11:7]};
				end
				// target is pc plus the branch offset
				`RV32_BEQ: begin
					p.cond_branch = 1'b1;
					p.channel     = ch_br;
					p.opa_select  = opa_is_pc;
					p.opb_select  = opb_is_b_imm;
					p.imm         = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				end
				`RV32_LUI: begin
					writes_rd    = 1'b1;
					p.opa_select = opa_is_zero;
					p.opb_select = opb_is_u_imm;
					p.imm        = {ins[31:12], 12'h000};
				end
				// jal links into rd
				`RV32_JAL: begin
					writes_rd       = 1'b1;
					p.uncond_branch = 1'b1;
					p.channel       = ch_br;
					p.opa_select    = opa_is_pc;
					p.opb_select    = opb_is_j_imm;
					p.imm           = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				end
				`RV32_WFI: p.halt = 1'b1;
				default:   p.illegal = 1'b1;
			endcase
			p.valid        = !p.illegal;
			p.dest_reg_idx = writes_rd ? ins[11:7] : 5'd0;
		end
		return p;
	endfunction

	always_comb begin
		next_exp = predict(if_id_packet_in);
	end

	// shadow writes follow the retire port while expectations follow the stall rule
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				shadow[i] <= '0;
			end
			exp_pkt <= '0;
			exp_btb <= '0;
		end else begin
			if (rob_retire_packet_in.valid && rob_retire_packet_in.dest_reg_idx != 5'd0) begin
				shadow[rob_retire_packet_in.dest_reg_idx] <= rob_retire_packet_in.dest_reg_value;
			end
			if (!stall) begin
				exp_pkt <= next_exp;
				exp_btb <= '{pc: if_id_packet_in.pc,
					valid: next_exp.valid & (next_exp.cond_branch | next_exp.uncond_branch)};
			end
		end
	end

	//////////////////////////////////////////////////
	// checks on the registered outputs
	//////////////////////////////////////////////////

	a_valid: assert property (@(posedge clock) disable iff (reset)
		id_packet_out.valid == exp_pkt.valid)
		else begin
			error_count++;
			$error("Fail valid expected %b actual %b",
				$sampled(exp_pkt.valid), $sampled(id_packet_out.valid));
		end

	// rs1 then rs2 in one 64-bit word
	a_operands: assert property (@(posedge clock) disable iff (reset)
		id_packet_out.rs1_value == exp_pkt.rs1_value &&
		id_packet_out.rs2_value == exp_pkt.rs2_value)
		else begin
			error_count++;
			$error("Fail operands expected %h actual %h",
				$sampled({exp_pkt.rs1_value, exp_pkt.rs2_value}),
				$sampled({id_packet_out.rs1_value, id_packet_out.rs2_value}));
		end

	// function, channel, memory and branch flags, halt, illegal and dest index
	a_control: assert property (@(posedge clock) disable iff (reset)
		{id_packet_out.alu_func, id_packet_out.channel, id_packet_out.rd_mem,
		id_packet_out.wr_mem, id_packet_out.cond_branch, id_packet_out.uncond_branch,
		id_packet_out.halt, id_packet_out.illegal, id_packet_out.dest_reg_idx} ==
		{exp_pkt.alu_func, exp_pkt.channel, exp_pkt.rd_mem, exp_pkt.wr_mem,
		exp_pkt.cond_branch, exp_pkt.uncond_branch, exp_pkt.halt, exp_pkt.illegal,
		exp_pkt.dest_reg_idx})
		else begin
			error_count++;
			$error("Fail control expected %h actual %h",
				$sampled({exp_pkt.alu_func, exp_pkt.channel, exp_pkt.rd_mem, exp_pkt.wr_mem,
				exp_pkt.cond_branch, exp_pkt.uncond_branch, exp_pkt.halt, exp_pkt.illegal,
				exp_pkt.dest_reg_idx}),
				$sampled({id_packet_out.alu_func, id_packet_out.channel, id_packet_out.rd_mem,
				id_packet_out.wr_mem, id_packet_out.cond_branch, id_packet_out.uncond_branch,
				id_packet_out.halt, id_packet_out.illegal, id_packet_out.dest_reg_idx}));
		end

	// operand a and b sources and the csr flag
	a_select: assert property (@(posedge clock) disable iff (reset)
		{id_packet_out.opa_select, id_packet_out.opb_select, id_packet_out.csr_op} ==
		{exp_pkt.opa_select, exp_pkt.opb_select, exp_pkt.csr_op})
		else begin
			error_count++;
			$error("Fail select expected %h actual %h",
				$sampled({exp_pkt.opa_select, exp_pkt.opb_select, exp_pkt.csr_op}),
				$sampled({id_packet_out.opa_select, id_packet_out.opb_select,
				id_packet_out.csr_op}));
		end

	a_imm: assert property (@(posedge clock) disable iff (reset)
		id_packet_out.imm == exp_pkt.imm)
		else begin
			error_count++;
			$error("Fail imm expected %h actual %h",
				$sampled(exp_pkt.imm), $sampled(id_packet_out.imm));
		end

	// inst, pc and npc ride along with valid work
	a_fields: assert property (@(posedge clock) disable iff (reset)
		exp_pkt.valid |-> (id_packet_out.pc == exp_pkt.pc &&
		id_packet_out.npc == exp_pkt.npc && id_packet_out.inst == exp_pkt.inst))
		else begin
			error_count++;
			$error("Fail fields expected %h actual %h",
				$sampled({exp_pkt.inst, exp_pkt.pc, exp_pkt.npc}),
				$sampled({id_packet_out.inst, id_packet_out.pc, id_packet_out.npc}));
		end

	a_btb: assert property (@(posedge clock) disable iff (reset)
		id2btb_packet_out == exp_btb)
		else begin
			error_count++;
			$error("Fail btb expected %h actual %h",
				$sampled(exp_btb), $sampled(id2btb_packet_out));
		end

	// back pressure freezes both outputs
	a_stall_hold: assert property (@(posedge clock) disable iff (reset)
		stall |=> ($stable(id_packet_out) && $stable(id2btb_packet_out)))
		else begin
			error_count++;
			$error("decode outputs changed while stall was high");
		end

endmodule

// attach the checker to every id_stage instance
bind id_stage id_stage_asserts u_asserts (.*);

// File: tb_id_stage.sv
// tb_id_stage: clock, reset and directed plus random fetch stimulus for the decode stage
module tb_id_stage import sys_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// roughly twice the cycles that all sequences below take
	localparam int max_cycles = 400;
	localparam if_id_packet_t   no_fetch = '0;
	localparam rob2reg_packet_t no_write = '0;

	logic            clock;
	logic            reset;
	logic            stall;
	if_id_packet_t   if_in;
	rob2reg_packet_t rob_in;
	id_packet_t      id_out;
	id2btb_packet_t  btb_out;
	int              cycles = 0;

	id_stage u_id_stage (
		.clock                (clock),
		.reset                (reset),
		.stall                (stall),
		.if_id_packet_in      (if_in),
		.rob_retire_packet_in (rob_in),
		.id_packet_out        (id_out),
		.id2btb_packet_out    (btb_out)
	);

	// 8 ns period
	always #4 clock = ~clock;

	//////////////////////////////////////////////////
	// watchdogs
	//////////////////////////////////////////////////

	// the bound checker counts its failed assertions
	always @(negedge clock) begin
		if (u_id_stage.u_asserts.error_count != 0) begin
			$display("Done: errors found");
			$fatal(1, "a decode check failed, see the Fail line above");
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("timeout: sequences did not finish within %0d cycles", max_cycles);
			$display("Done: errors found");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// one rising edge, all inputs change together
	task automatic step(input if_id_packet_t f, input rob2reg_packet_t w, input logic s);
		@(posedge clock);
		if_in  <= f;
		rob_in <= w;
		stall  <= s;
	endtask

	// valid fetch at a random word aligned pc
	function automatic if_id_packet_t fetch(input logic [31:0] ins);
		if_id_packet_t f;
		logic [31:0]   rnd;
		rnd     = $urandom;
		f.inst  = ins;
		f.pc    = {rnd[31:2], 2'b00};
		f.npc   = f.pc + 32'd4;
		f.valid = 1'b1;
		return f;
	endfunction

	function automatic rob2reg_packet_t retire_write(input logic [4:0] idx,
		input logic [31:0] val);
		return {1'b1, idx, val};
	endfunction

	// register fields random, funct7 and funct3 fixed
	function automatic logic [31:0] r_form(input logic [6:0] f7, input logic [2:0] f3);
		logic [31:0] rnd;
		rnd = $urandom;
		return {f7, rnd[24:15], f3, rnd[11:7], 7'b0110011};
	endfunction

	// i, s and b share the funct3 position, everything else random
	function automatic logic [31:0] i_form(input logic [2:0] f3, input logic [6:0] op);
		logic [31:0] rnd;
		rnd = $urandom;
		return {rnd[31:15], f3, rnd[11:7], op};
	endfunction

	function automatic logic [31:0] u_form(input logic [6:0] op);
		logic [31:0] rnd;
		rnd = $urandom;
		return {rnd[31:7], op};
	endfunction

	//////////////////////////////////////////////////
	// sequences
	//////////////////////////////////////////////////

	initial begin
		logic [31:0]   ins;
		if_id_packet_t held;
		int            i;
		void'($urandom(32'hb32a_41c3));
		clock  = 1'b0;
		reset  = 1'b1;
		stall  = 1'b0;
		if_in  = no_fetch;
		rob_in = no_write;
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		// idle and invalid slots keep both valids low
		repeat (3) step(no_fetch, no_write, 1'b0);
		held       = fetch($urandom);
		held.valid = 1'b0;
		step(held, no_write, 1'b0);
		step(no_fetch, no_write, 1'b0);

		// fill every register through the retire port
		for (i = 1; i < 32; i++) begin
			step(no_fetch, retire_write(i[4:0], $urandom), 1'b0);
		end
		repeat (32) step(fetch(r_form(7'b0000000, 3'b000)), no_write, 1'b0);

		// same cycle write to rs1 comes through the bypass
		repeat (8) begin
			ins = r_form(7'b0000000, 3'b000);
			step(fetch(ins), retire_write(ins[19:15], $urandom), 1'b0);
		end

		// x0 stays zero even when written
		ins        = r_form(7'b0000000, 3'b000);
		ins[24:15] = 10'd0;
		step(fetch(ins), retire_write(5'd0, $urandom), 1'b0);
		step(fetch(ins), no_write, 1'b0);

		// add, sub, and, xor, mul, mulhu
		step(fetch(r_form(7'b0000000, 3'b000)), no_write, 1'b0);
		step(fetch(r_form(7'b0100000, 3'b000)), no_write, 1'b0);
		step(fetch(r_form(7'b0000000, 3'b111)), no_write, 1'b0);
		step(fetch(r_form(7'b0000000, 3'b100)), no_write, 1'b0);
		step(fetch(r_form(7'b0000001, 3'b000)), no_write, 1'b0);
		step(fetch(r_form(7'b0000001, 3'b011)), no_write, 1'b0);

		// addi, lw, sw, beq, lui, jal with random immediate bits
		repeat (10) begin
			step(fetch(i_form(3'b000, 7'b0010011)), no_write, 1'b0);
			step(fetch(i_form(3'b010, 7'b0000011)), no_write, 1'b0);
			step(fetch(i_form(3'b010, 7'b0100011)), no_write, 1'b0);
			step(fetch(i_form(3'b000, 7'b1100011)), no_write, 1'b0);
			step(fetch(u_form(7'b0110111)), no_write, 1'b0);
			step(fetch(u_form(7'b1101111)), no_write, 1'b0);
		end

		// two illegal encodings, then wfi
		step(fetch(32'h0000_0000), no_write, 1'b0);
		step(fetch(u_form(7'b1111111)), no_write, 1'b0);
		step(fetch(32'h1050_0073), no_write, 1'b0);

		// jal sits in the register while junk arrives under stall
		step(fetch(u_form(7'b1101111)), no_write, 1'b0);
		repeat (8) begin
			ins = $urandom;
			step(fetch($urandom), retire_write(ins[4:0], ins), 1'b1);
		end
		// upstream holds a beq across the release
		held = fetch(i_form(3'b000, 7'b1100011));
		step(held, no_write, 1'b1);
		step(held, no_write, 1'b0);
		repeat (3) step(no_fetch, no_write, 1'b0);

		@(negedge clock);
		if (u_id_stage.u_asserts.error_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "decode checks recorded failures");
		end
	end

endmodule

// File: sources.f
+incdir+.
sys_pkg.sv
decoder.sv
regfile.sv
id_latch.sv
id_stage.sv
id_stage_asserts.sv
tb_id_stage.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode stage testbench, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -j 0 --top-module tb_id_stage -f sources.f -o sim_id_stage &&
./obj_dir/sim_id_stage +verilator+error+limit+100 > sim.log 2>&1
grep -q "Done: no errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
